// File: hdl/mw_pkg.sv
`default_nettype none

package mw_pkg;

    // base opcodes of the rv32i instructions seen by this stage
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_ari_itype = 7'b0010011;
    localparam logic [6:0] opc_ari_rtype = 7'b0110011;
    localparam logic [6:0] opc_csr       = 7'b1110011;

    // load widths
    localparam logic [2:0] fnc_lb  = 3'b000;
    localparam logic [2:0] fnc_lh  = 3'b001;
    localparam logic [2:0] fnc_lw  = 3'b010;
    localparam logic [2:0] fnc_lbu = 3'b100;
    localparam logic [2:0] fnc_lhu = 3'b101;

    // store widths
    localparam logic [2:0] fnc_sb = 3'b000;
    localparam logic [2:0] fnc_sh = 3'b001;
    localparam logic [2:0] fnc_sw = 3'b010;

    // csr writes, register source and immediate source
    localparam logic [2:0] fnc_rw  = 3'b001;
    localparam logic [2:0] fnc_rwi = 3'b101;

    localparam logic [11:0] csr_tohost = 12'h51e;

    // writeback source
    localparam logic [1:0] sel_alu = 2'd0;
    localparam logic [1:0] sel_mem = 2'd1;
    localparam logic [1:0] sel_pc4 = 2'd2;

    // word address width of each byte lane, 256 entries deep
    localparam int dmem_addr_bits = 8;

    // one instruction word, read as I type or as S type
    typedef union packed {
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            // imm[11:5]
            logic [6:0]  imm_hi;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            // imm[4:0]
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } s_view;
    } rv_inst_t;

endpackage

`default_nettype wire

// File: hdl/mw_control.sv
`default_nettype none

module mw_control (
    input  mw_pkg::rv_inst_t inst,
    output logic [3:0]       w_mask,
    output logic             re,
    output logic [1:0]       wb_sel,
    output logic             rwe,
    output logic             csr_we
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] csr_idx;

    assign opcode  = inst.i_view.opcode;
    assign funct3  = inst.i_view.funct3;
    // the csr index sits where the I immediate would be
    assign csr_idx = inst.i_view.imm12;

    always_comb begin
        w_mask = 4'b0000;
        re     = 1'b0;
        wb_sel = mw_pkg::sel_alu;
        rwe    = 1'b0;
        case (opcode)
            mw_pkg::opc_lui,
            mw_pkg::opc_auipc,
            mw_pkg::opc_ari_itype,
            mw_pkg::opc_ari_rtype: begin
                wb_sel = mw_pkg::sel_alu;
                rwe    = 1'b1;
            end
            mw_pkg::opc_jal,
            mw_pkg::opc_jalr: begin
                wb_sel = mw_pkg::sel_pc4;
                rwe    = 1'b1;
            end
            mw_pkg::opc_load: begin
                re     = 1'b1;
                wb_sel = mw_pkg::sel_mem;
                rwe    = 1'b1;
            end
            mw_pkg::opc_store: begin
                // mask is left aligned to lane 0 here, mem_request shifts it
                case (funct3)
                    mw_pkg::fnc_sb: w_mask = 4'b0001;
                    mw_pkg::fnc_sh: w_mask = 4'b0011;
                    mw_pkg::fnc_sw: w_mask = 4'b1111;
                    default:        w_mask = 4'b0000;
                endcase
            end
            // branch and csr write nothing back
            mw_pkg::opc_branch,
            mw_pkg::opc_csr: begin
                rwe = 1'b0;
            end
            default: begin
                rwe = 1'b0;
            end
        endcase
    end

    // only tohost exists, every other csr index is ignored
    assign csr_we = (opcode == mw_pkg::opc_csr) &&
                    ((funct3 == mw_pkg::fnc_rw) || (funct3 == mw_pkg::fnc_rwi)) &&
                    (csr_idx == mw_pkg::csr_tohost);

endmodule

`default_nettype wire

// File: hdl/mem_request.sv
`default_nettype none

module mem_request (
    input  logic                              in_valid,
    input  mw_pkg::rv_inst_t                  inst,
    input  logic [31:0]                       rs1_data,
    input  logic [31:0]                       rs2_data,
    input  logic [3:0]                        w_mask,
    output logic [mw_pkg::dmem_addr_bits-1:0] word_addr,
    output logic [1:0]                        byte_offset,
    output logic [3:0]                        lane_we,
    output logic [3:0][7:0]                   lane_wdata
);

    logic        is_store;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] eff_addr;
    logic [3:0]  byte_mask;
    logic [31:0] store_word;

    assign is_store = (inst.s_view.opcode == mw_pkg::opc_store);

    // stores split the immediate around rd, loads keep it whole
    assign imm_i = {{20{inst.i_view.imm12[11]}}, inst.i_view.imm12};
    assign imm_s = {{20{inst.s_view.imm_hi[6]}}, inst.s_view.imm_hi, inst.s_view.imm_lo};

    assign eff_addr    = rs1_data + (is_store ? imm_s : imm_i);
    assign word_addr   = eff_addr[mw_pkg::dmem_addr_bits+1:2];
    assign byte_offset = eff_addr[1:0];

    // mask bits pushed past lane 3 fall off
    assign byte_mask  = w_mask << byte_offset;
    assign store_word = rs2_data << {byte_offset, 3'b000};

    assign lane_we = in_valid ? byte_mask : 4'b0000;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_wdata[i] = store_word[8*i +: 8];
        end
    end

    // no misalignment trap in this stage, so partial stores must stay in one word
    always_comb begin
        if (in_valid && is_store) begin
            if (inst.s_view.funct3 == mw_pkg::fnc_sh) begin
                assert final (byte_offset != 2'd3)
                else $error("sh crosses a word boundary, offset 3");
            end
            if (inst.s_view.funct3 == mw_pkg::fnc_sw) begin
                assert final (byte_offset == 2'd0)
                else $error("sw not word aligned, offset %0d", byte_offset);
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/dmem_bank.sv
`default_nettype none

module dmem_bank (
    input  logic                              clk,
    input  logic [mw_pkg::dmem_addr_bits-1:0] addr,
    input  logic                              we,
    input  logic [7:0]                        wdata,
    output logic [7:0]                        rdata
);

    // one byte lane of the data memory
    logic [7:0] mem [0:(1 << mw_pkg::dmem_addr_bits)-1];

    // a read at the address being written returns the old byte
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: hdl/writeback_unit.sv
`default_nettype none

module writeback_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  mw_pkg::rv_inst_t inst,
    input  logic             rwe,
    input  logic             re,
    input  logic [1:0]       wb_sel,
    input  logic             csr_we,
    input  logic [1:0]       byte_offset,
    input  logic [31:0]      alu_result,
    input  logic [31:0]      pc,
    input  logic [31:0]      rs1_data,
    input  logic [3:0][7:0]  bank_rdata,
    output logic             wb_valid,
    output logic             wb_we,
    output logic [4:0]       wb_rd,
    output logic [31:0]      wb_data,
    output logic [31:0]      tohost
);

    logic        valid_q;
    logic        we_q;
    logic        re_q;
    logic [1:0]  sel_q;
    logic [2:0]  funct3_q;
    logic [1:0]  offset_q;
    logic [4:0]  rd_q;
    logic [31:0] alu_q;
    logic [31:0] pc4_q;
    logic [31:0] tohost_q;
    logic [31:0] mem_word;
    logic [31:0] mem_shifted;
    logic [31:0] load_data;

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q  <= 1'b0;
            we_q     <= 1'b0;
            re_q     <= 1'b0;
            tohost_q <= 32'd0;
        end else begin
            valid_q <= in_valid;
            we_q    <= in_valid && rwe;
            re_q    <= in_valid && re;
            if (in_valid && csr_we) begin
                // csrrwi carries a 5 bit immediate in the rs1 field
                if (inst.i_view.funct3 == mw_pkg::fnc_rwi) begin
                    tohost_q <= {27'd0, inst.i_view.rs1};
                end else begin
                    tohost_q <= rs1_data;
                end
            end
        end
    end

    // payload registers line up with the bank read data
    always_ff @(posedge clk) begin
        sel_q    <= wb_sel;
        funct3_q <= inst.i_view.funct3;
        offset_q <= byte_offset;
        rd_q     <= inst.i_view.rd;
        alu_q    <= alu_result;
        pc4_q    <= pc + 32'd4;
    end

    // lane 3 is the top byte of the word
    assign mem_word    = bank_rdata;
    assign mem_shifted = mem_word >> {offset_q, 3'b000};

    always_comb begin
        case (funct3_q)
            mw_pkg::fnc_lb:  load_data = {{24{mem_shifted[7]}}, mem_shifted[7:0]};
            mw_pkg::fnc_lh:  load_data = {{16{mem_shifted[15]}}, mem_shifted[15:0]};
            mw_pkg::fnc_lw:  load_data = mem_word;
            mw_pkg::fnc_lbu: load_data = {24'd0, mem_shifted[7:0]};
            mw_pkg::fnc_lhu: load_data = {16'd0, mem_shifted[15:0]};
            default:         load_data = mem_word;
        endcase
    end

    always_comb begin
        case (sel_q)
            mw_pkg::sel_mem: wb_data = re_q ? load_data : 32'd0;
            mw_pkg::sel_pc4: wb_data = pc4_q;
            default:         wb_data = alu_q;
        endcase
    end

    assign wb_valid = valid_q;
    assign wb_we    = we_q;
    assign wb_rd    = rd_q;
    assign tohost   = tohost_q;

    // no misalignment trap, so the extracted bytes must lie in the read word
    a_lw_aligned: assert property (@(posedge clk) disable iff (reset)
        (re_q && funct3_q == mw_pkg::fnc_lw) |-> (offset_q == 2'd0))
    else $error("lw not word aligned, offset %0d", offset_q);

    a_lh_in_word: assert property (@(posedge clk) disable iff (reset)
        (re_q && (funct3_q == mw_pkg::fnc_lh || funct3_q == mw_pkg::fnc_lhu))
        |-> (offset_q != 2'd3))
    else $error("halfword load crosses a word boundary, offset 3");

endmodule

`default_nettype wire

// File: hdl/mw_stage.sv
`default_nettype none

module mw_stage (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  logic [31:0] inst,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic [31:0] alu_result,
    input  logic [31:0] pc,
    output logic        wb_valid,
    output logic        wb_we,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data,
    output logic [31:0] tohost
);

    logic [3:0]                        w_mask;
    logic                              re;
    logic [1:0]                        wb_sel;
    logic                              rwe;
    logic                              csr_we;
    logic [mw_pkg::dmem_addr_bits-1:0] word_addr;
    logic [1:0]                        byte_offset;
    logic [3:0]                        lane_we;
    logic [3:0][7:0]                   lane_wdata;
    logic [3:0][7:0]                   bank_rdata;

    mw_control ctrl0 (
        .inst   (inst),
        .w_mask (w_mask),
        .re     (re),
        .wb_sel (wb_sel),
        .rwe    (rwe),
        .csr_we (csr_we)
    );

    mem_request req0 (
        .in_valid    (in_valid),
        .inst        (inst),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .w_mask      (w_mask),
        .word_addr   (word_addr),
        .byte_offset (byte_offset),
        .lane_we     (lane_we),
        .lane_wdata  (lane_wdata)
    );

    // four byte lanes, all at the same word address
    for (genvar i = 0; i < 4; i++) begin : g_bank
        dmem_bank bank (
            .clk   (clk),
            .addr  (word_addr),
            .we    (lane_we[i]),
            .wdata (lane_wdata[i]),
            .rdata (bank_rdata[i])
        );
    end

    writeback_unit wb0 (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .inst        (inst),
        .rwe         (rwe),
        .re          (re),
        .wb_sel      (wb_sel),
        .csr_we      (csr_we),
        .byte_offset (byte_offset),
        .alu_result  (alu_result),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .bank_rdata  (bank_rdata),
        .wb_valid    (wb_valid),
        .wb_we       (wb_we),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .tohost      (tohost)
    );

endmodule

`default_nettype wire

// File: test/tb_mw_stage.sv
`default_nettype none

module tb_mw_stage;

    localparam int half_period  = 20;
    localparam int edge_timeout = 100;
    localparam int reset_cycles = 3;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic [31:0] inst;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] alu_result;
    logic [31:0] pc;
    logic        wb_valid;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic [31:0] tohost;

    int edge_count = 0;
    bit timed_out;
    int pass_count;
    int error_count;

    mw_stage dut0 (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .inst       (inst),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .pc         (pc),
        .wb_valid   (wb_valid),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .tohost     (tohost)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

    // nonblocking, so a poll landing on the edge still sees the old count
    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // returns one time unit after the next rising edge
    task automatic wait_clock_edge();
        int start;
        int waited;
        start  = edge_count;
        waited = 0;
        while (edge_count == start && waited < edge_timeout) begin
            #1;
            waited++;
        end
        if (edge_count == start) begin
            $display("timeout, no rising clock edge within %0d time units", edge_timeout);
            timed_out = 1'b1;
        end
    endtask

    task automatic skip_line(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    // rd and data only matter when full is set
    task automatic check_outputs(input logic [8*32-1:0] name, input logic exp_valid,
                                 input logic exp_we, input logic [4:0] exp_rd,
                                 input logic [31:0] exp_data, input logic [31:0] exp_tohost,
                                 input logic full);
        if (wb_valid !== exp_valid) begin
            $display("** Error %0s: wb_valid expected %0h actual %0h", name, exp_valid, wb_valid);
            error_count++;
        end else if (wb_we !== exp_we) begin
            $display("** Error %0s: wb_we expected %0h actual %0h", name, exp_we, wb_we);
            error_count++;
        end else if (full && wb_rd !== exp_rd) begin
            $display("** Error %0s: wb_rd expected %0d actual %0d", name, exp_rd, wb_rd);
            error_count++;
        end else if (full && wb_data !== exp_data) begin
            $display("** Error %0s: wb_data expected %08h actual %08h", name, exp_data, wb_data);
            error_count++;
        end else if (tohost !== exp_tohost) begin
            $display("** Error %0s: tohost expected %08h actual %08h", name, exp_tohost, tohost);
            error_count++;
        end else begin
            $display("ok   %0s", name);
            pass_count++;
        end
    endtask

    initial begin
        int              fd;
        int              code;
        int              cycles;
        bit              done;
        logic [8*32-1:0] tok;
        logic [31:0]     f_valid;
        logic [31:0]     f_inst;
        logic [31:0]     f_rs1;
        logic [31:0]     f_rs2;
        logic [31:0]     f_alu;
        logic [31:0]     f_pc;
        logic [31:0]     f_we;
        logic [31:0]     f_rd;
        logic [31:0]     f_data;
        logic [31:0]     f_tohost;
        logic [31:0]     f_full;

        reset       = 1'b1;
        in_valid    = 1'b0;
        inst        = 32'd0;
        rs1_data    = 32'd0;
        rs2_data    = 32'd0;
        alu_result  = 32'd0;
        pc          = 32'd0;
        timed_out   = 1'b0;
        pass_count  = 0;
        error_count = 0;
        done        = 1'b0;

        fd = $fopen("test/mw_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open test/mw_tests.txt");
            error_count++;
            done = 1'b1;
        end

        cycles = 0;
        while (cycles < reset_cycles && !timed_out) begin
            wait_clock_edge();
            cycles++;
        end
        if (!timed_out) begin
            check_outputs("reset", 1'b0, 1'b0, 5'd0, 32'd0, 32'd0, 1'b0);
        end
        #1;
        reset = 1'b0;

        // each pass starts 2 units after an edge
        while (!done && !timed_out) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else if (tok == 256'h23) begin
                skip_line(fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f_valid, f_inst,
                               f_rs1, f_rs2, f_alu, f_pc, f_we, f_rd, f_data, f_tohost, f_full);
                if (code != 11) begin
                    $display("line for %0s in test/mw_tests.txt has missing fields", tok);
                    error_count++;
                    done = 1'b1;
                end else begin
                    in_valid   = f_valid[0];
                    inst       = f_inst;
                    rs1_data   = f_rs1;
                    rs2_data   = f_rs2;
                    alu_result = f_alu;
                    pc         = f_pc;
                    wait_clock_edge();
                    if (!timed_out) begin
                        check_outputs(tok, f_valid[0], f_we[0], f_rd[4:0], f_data,
                                      f_tohost, f_full[0]);
                        #1;
                    end
                end
            end
        end
        in_valid = 1'b0;

        if (fd != 0) begin
            $fclose(fd);
        end
        $display("summary: %0d checks ok, %0d with errors", pass_count, error_count);
        if (error_count == 0 && !timed_out && pass_count > 1) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/mw_tests.txt
# name valid inst rs1_data rs2_data alu_result pc exp_wb_we exp_wb_rd exp_wb_data exp_tohost full
# all fields hex, full=1 also compares wb_rd and wb_data, wb_valid is expected equal to valid
add_x5      1 002082b3 00000000 00000000 12345678 00000000 1 05 12345678 00000000 1
addi_x6     1 00508313 00000000 00000000 fffffff0 00000004 1 06 fffffff0 00000000 1
lui_x7      1 abcde3b7 00000000 00000000 abcde000 00000008 1 07 abcde000 00000000 1
auipc_x8    1 00001417 00000000 00000000 00001200 00000200 1 08 00001200 00000000 1
jal_x1      1 008000ef 00000000 00000000 0000dead 00000300 1 01 00000304 00000000 1
jalr_x1     1 000100e7 00000000 00000000 0000beef 00001000 1 01 00001004 00000000 1
beq_nowb    1 00208463 00000000 00000000 00000000 00000010 0 00 00000000 00000000 0
sw_word     1 0020a023 00000100 11223344 00000000 00000000 0 00 00000000 00000000 0
lw_word     1 0000a503 00000100 00000000 00000000 00000000 1 0a 11223344 00000000 1
sb_off0     1 00208023 00000100 000000ee 00000000 00000000 0 00 00000000 00000000 0
lw_sb_off0  1 0000a503 00000100 00000000 00000000 00000000 1 0a 112233ee 00000000 1
sb_off1     1 002080a3 00000100 aaaaaa55 00000000 00000000 0 00 00000000 00000000 0
lw_sb_off1  1 0000a503 00000100 00000000 00000000 00000000 1 0a 112255ee 00000000 1
sb_off2     1 00208123 00000100 00000077 00000000 00000000 0 00 00000000 00000000 0
lw_sb_off2  1 0000a503 00000100 00000000 00000000 00000000 1 0a 117755ee 00000000 1
sb_off3     1 002081a3 00000100 00000099 00000000 00000000 0 00 00000000 00000000 0
lw_sb_off3  1 0000a503 00000100 00000000 00000000 00000000 1 0a 997755ee 00000000 1
sh_off0     1 00209023 00000100 0000beef 00000000 00000000 0 00 00000000 00000000 0
lw_sh_off0  1 0000a503 00000100 00000000 00000000 00000000 1 0a 9977beef 00000000 1
sh_off1     1 002090a3 00000100 ffff8001 00000000 00000000 0 00 00000000 00000000 0
lw_sh_off1  1 0000a503 00000100 00000000 00000000 00000000 1 0a 998001ef 00000000 1
sh_off2     1 00209123 00000100 0000c0de 00000000 00000000 0 00 00000000 00000000 0
lw_sh_off2  1 0000a503 00000100 00000000 00000000 00000000 1 0a c0de01ef 00000000 1
lb_off0     1 00008583 00000100 00000000 00000000 00000000 1 0b ffffffef 00000000 1
lb_off1     1 00108583 00000100 00000000 00000000 00000000 1 0b 00000001 00000000 1
lb_off2     1 00208583 00000100 00000000 00000000 00000000 1 0b ffffffde 00000000 1
lb_off3     1 00308583 00000100 00000000 00000000 00000000 1 0b ffffffc0 00000000 1
lbu_off0    1 0000c583 00000100 00000000 00000000 00000000 1 0b 000000ef 00000000 1
lbu_off1    1 0010c583 00000100 00000000 00000000 00000000 1 0b 00000001 00000000 1
lbu_off2    1 0020c583 00000100 00000000 00000000 00000000 1 0b 000000de 00000000 1
lbu_off3    1 0030c583 00000100 00000000 00000000 00000000 1 0b 000000c0 00000000 1
lh_off0     1 00009583 00000100 00000000 00000000 00000000 1 0b 000001ef 00000000 1
lh_off2     1 00209583 00000100 00000000 00000000 00000000 1 0b ffffc0de 00000000 1
lhu_off0    1 0000d583 00000100 00000000 00000000 00000000 1 0b 000001ef 00000000 1
lhu_off2    1 0020d583 00000100 00000000 00000000 00000000 1 0b 0000c0de 00000000 1
idle_sw     0 0020a023 00000100 ffffffff 00000000 00000000 0 00 00000000 00000000 0
lw_idle     1 0000a503 00000100 00000000 00000000 00000000 1 0a c0de01ef 00000000 1
sw_neg_imm  1 fe20ac23 00000208 5a5aa5a5 00000000 00000000 0 00 00000000 00000000 0
lw_neg_imm  1 ffc0a603 00000204 00000000 00000000 00000000 1 0c 5a5aa5a5 00000000 1
csrrw_host  1 51e09073 cafef00d 00000000 00000000 00000000 0 00 00000000 cafef00d 0
csrrwi_host 1 51ead073 ffffffff 00000000 00000000 00000000 0 00 00000000 00000015 0
csrrw_other 1 34009073 12345678 00000000 00000000 00000000 0 00 00000000 00000015 0

// File: list.f
hdl/mw_pkg.sv
hdl/mw_control.sv
hdl/mem_request.sv
hdl/dmem_bank.sv
hdl/writeback_unit.sv
hdl/mw_stage.sv
test/tb_mw_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mw_stage testbench with verilator, run from the project root

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_mw_stage
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_mw_stage > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$log"; then
    exit 1
fi

if ! grep -q "test passed" "$log"; then
    echo "no verdict found in $log"
    exit 1
fi

exit 0
